// File: files.f
u2_ctrl_pkg.sv
wb_decoder.sv
settings_bus.sv
control_regs.sv
pic.sv
readback_mux.sv
u2_ctrl_top.sv
tb_u2_ctrl_props.sv
tb_u2_ctrl.sv

// File: Makefile
# Verilator build and run of the control-plane testbench
TOP := tb_u2_ctrl

.PHONY: all lint clean

# Build, run, and pass only when the pass message shows up
all:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: tb_u2_ctrl.sv
/* Testbench for the control-plane core, acting as the bus master
   Clock, reset, bus tasks, LFSR stimulus, reference model, checks, timeout and summary */

`timescale 1ns/1ps
`default_nettype none

module tb_u2_ctrl;

   import u2_ctrl_pkg::*;

   // All tests together take about 400 cycles
   // Limit allows ten times that
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int BUS_WAIT_MAX   = 8;
   localparam logic [15:0] SET_BASE  = {SLV_SETTINGS, 10'b0};
   localparam logic [15:0] RDBK_BASE = {SLV_RDBK, 10'b0};
   localparam logic [15:0] PIC_BASE  = {SLV_PIC, 10'b0};
   localparam logic [15:0] PIC_PEND  = PIC_BASE + 16'd4;
   localparam logic [15:0] UNMAPPED  = 16'h0400;

   // Reference model selectors
   localparam int REF_CLK   = 0;
   localparam int REF_SER   = 1;
   localparam int REF_ADC   = 2;
   localparam int REF_PHYN  = 3;
   localparam int REF_LEDS  = 4;
   localparam int REF_PRIO  = 5;
   localparam int REF_WORD9 = 6;
   localparam int REF_EDGE  = 7;
   localparam int REF_CLR   = 8;
   localparam int REF_INT   = 9;

   logic               dsp_clk;
   logic               wb_rst;
   wb_req_t            req;
   wb_rsp_t            rsp;
   logic [NUM_IRQ-1:0] irq;
   logic               clk_status;
   logic               serdes_link_up;
   logic               sim_mode;
   logic [3:0]         clock_divider;
   clock_ctrl_t        clock_ctrl;
   serdes_ctrl_t       serdes_ctrl;
   adc_ctrl_t          adc_ctrl;
   logic               phy_resetn;
   logic [7:0]         leds;
   logic               int_out;

   logic [31:0] lfsr_state = 32'h9464d036;
   int          cycle_count = 0;
   int          error_count = 0;
   int          check_count = 0;
   int          test_count = 0;
   int          test_base_errors = 0;
   int          last_ack_cycle;
   logic        last_ack;
   logic        last_err;
   logic [31:0] sh_clk = '0;
   logic [31:0] sh_ser = '0;
   logic [31:0] sh_adc = '0;
   logic [31:0] sh_phy = '0;

   // Pending comparisons, drained by the compare process
   string       name_q[$];
   logic [31:0] exp_q[$];
   logic [31:0] act_q[$];

   u2_ctrl_top #(.NUM_IRQ(NUM_IRQ)) dut (
      .dsp_clk         (dsp_clk),
      .wb_rst          (wb_rst),
      .wb_req_i        (req),
      .wb_rsp_o        (rsp),
      .irq_i           (irq),
      .clk_status_i    (clk_status),
      .serdes_link_up_i(serdes_link_up),
      .sim_mode_i      (sim_mode),
      .clock_divider_i (clock_divider),
      .clock_ctrl_o    (clock_ctrl),
      .serdes_ctrl_o   (serdes_ctrl),
      .adc_ctrl_o      (adc_ctrl),
      .phy_resetn_o    (phy_resetn),
      .leds_o          (leds),
      .int_o           (int_out)
   );

   // Handshake and strobe checks on the slave and the fabric
   bind settings_bus tb_u2_ctrl_props u_set_props (
      .clk_i(dsp_clk), .rst_i(wb_rst), .req_i(req_i), .rsp_i(rsp_o), .set_stb_i(set_o.stb)
   );
   bind wb_decoder tb_u2_ctrl_props u_dec_props (
      .clk_i(dsp_clk), .rst_i(wb_rst), .req_i(m_req_i), .rsp_i(m_rsp_o), .set_stb_i(1'b0)
   );

   ////////////////////
   // Clock, cycle count, timeout

   initial begin
      dsp_clk = 1'b0;
      forever #2 dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk) begin
      cycle_count <= cycle_count + 1;
   end

   initial begin
      while (cycle_count < TIMEOUT_CYCLES) @(posedge dsp_clk);
      $display("Run stopped, still busy after %0d cycles", cycle_count);
      $display("Test FAILED");
      $finish;
   end

   ////////////////////
   // Stimulus helpers

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         v = {v[30:0], lfsr_state[31]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   function automatic logic [15:0] set_addr(input logic [7:0] sr);
      return SET_BASE | {6'b0, sr, 2'b00};
   endfunction

   function automatic logic [15:0] rdbk_addr(input logic [3:0] w);
      return RDBK_BASE | {10'b0, w, 2'b00};
   endfunction

   // Expected values straight from the register and status rules
   function automatic logic [31:0] predict(input int kind, input logic [31:0] a,
                                           input logic [31:0] b, input logic [31:0] c);
      logic [31:0] r;
      logic [7:0]  hw;
      int          i;
      r = '0;
      case (kind)
         REF_CLK:   r = {27'b0, a[4:0]};
         REF_SER:   r = {28'b0, a[3:0]};
         REF_ADC:   r = {28'b0, a[3:0]};
         REF_PHYN:  r = {31'b0, ~a[0]};
         // Hardware word has clk_status at bit 1, link at bit 0
         REF_LEDS: begin
            hw = {6'b0, c[1:0]};
            for (i = 0; i < 8; i++) begin
               r[i] = b[i] ? hw[i] : a[i];
            end
         end
         // Search down from the top line, first hit wins
         REF_PRIO: begin
            for (i = NUM_IRQ - 1; i >= 0 && r == '0; i--) begin
               if (a[i]) begin
                  r = 32'(i + 1);
               end
            end
         end
         REF_WORD9: r = {a[0], 27'b0, b[3:0]};
         // Old pending plus lines that went from low to high
         REF_EDGE:  r = a | (c & ~b);
         REF_CLR:   r = a & ~b;
         REF_INT:   r = {31'b0, |(a & b)};
         default:   r = '0;
      endcase
      return r;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge dsp_clk);
      #1;
   endtask

   // Drive 1 ns after the edge, sample reply 1 ns after later edges
   task automatic bus_cycle(input logic [15:0] adr, input logic we, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int waited;
      @(posedge dsp_clk);
      #1;
      req = '{adr: adr, dat: wdat, sel: '1, we: we, cyc: 1'b1, stb: 1'b1};
      waited = 0;
      last_ack = 1'b0;
      last_err = 1'b0;
      rdat = '0;
      while (!last_ack && !last_err && waited < BUS_WAIT_MAX) begin
         @(posedge dsp_clk);
         #1;
         waited++;
         last_ack = rsp.ack;
         last_err = rsp.err;
         rdat = rsp.dat;
      end
      last_ack_cycle = cycle_count;
      req.cyc = 1'b0;
      req.stb = 1'b0;
      if (!last_ack && !last_err) begin
         $display("Bus access at 0x%04h got neither ack nor err within %0d cycles",
                  adr, BUS_WAIT_MAX);
         error_count++;
      end
   endtask

   task automatic bus_write(input logic [15:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      bus_cycle(adr, 1'b1, dat, unused);
      if (last_err) begin
         $display("Write to 0x%04h ended with an error reply", adr);
         error_count++;
      end
   endtask

   task automatic bus_read(input logic [15:0] adr, output logic [31:0] dat);
      bus_cycle(adr, 1'b0, '0, dat);
   endtask

   ////////////////////
   // Checking

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      check_count++;
      if (exp !== act) begin
         $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
         error_count++;
      end
   endtask

   task automatic post_check(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      name_q.push_back(name);
      exp_q.push_back(exp);
      act_q.push_back(act);
   endtask

   // Compare process
   always @(posedge dsp_clk) begin
      while (exp_q.size() > 0) begin
         check_value(name_q[0], exp_q[0], act_q[0]);
         name_q.delete(0);
         exp_q.delete(0);
         act_q.delete(0);
      end
   end

   // Waits for the queue to drain, then one line per test
   task automatic end_test(input string name);
      int errs;
      do begin
         @(posedge dsp_clk);
         #1;
      end while (exp_q.size() > 0);
      errs = error_count - test_base_errors;
      test_base_errors = error_count;
      test_count++;
      if (errs == 0) begin
         $display("%-14s passed", name);
      end else begin
         $display("%-14s failed, %0d errors", name, errs);
      end
   endtask

   // Write one pin register, check all pin groups two cycles later
   task automatic pin_write_check(input logic [7:0] sr);
      logic [31:0] d;
      d = rand_bits(32);
      bus_write(set_addr(sr), d);
      wait_cycles(2);
      case (sr)
         SR_CLK:  sh_clk = d;
         SR_SER:  sh_ser = d;
         SR_ADC:  sh_adc = d;
         default: sh_phy = d;
      endcase
      post_check("clock_ctrl", predict(REF_CLK, sh_clk, '0, '0), {27'b0, clock_ctrl});
      post_check("serdes_ctrl", predict(REF_SER, sh_ser, '0, '0), {28'b0, serdes_ctrl});
      post_check("adc_ctrl", predict(REF_ADC, sh_adc, '0, '0), {28'b0, adc_ctrl});
      post_check("phy_resetn", predict(REF_PHYN, sh_phy, '0, '0), {31'b0, phy_resetn});
   endtask

   ////////////////////
   // Test sequence

   initial begin
      logic [31:0] rdat;
      logic [31:0] rnd;
      logic [31:0] sw;
      logic [31:0] mask;
      logic [31:0] pend;
      logic [31:0] lines;
      logic [31:0] c1;
      int          t1;
      int          it;

      req = '0;
      irq = '0;
      clk_status = 1'b0;
      serdes_link_up = 1'b0;
      sim_mode = 1'b0;
      clock_divider = '0;
      wb_rst = 1'b1;
      repeat (16) @(posedge dsp_clk);
      #1;
      wb_rst = 1'b0;

      // Idle state out of reset
      post_check("reset_ack", '0, {30'b0, rsp.ack, rsp.err});
      post_check("reset_int", '0, {31'b0, int_out});
      post_check("reset_clk", predict(REF_CLK, '0, '0, '0), {27'b0, clock_ctrl});
      post_check("reset_phy", predict(REF_PHYN, '0, '0, '0), {31'b0, phy_resetn});
      end_test("reset_state");

      for (it = 0; it < 6; it++) begin
         pin_write_check(SR_CLK);
         pin_write_check(SR_SER);
         pin_write_check(SR_ADC);
         pin_write_check(SR_PHY);
      end
      end_test("pin_settings");

      for (it = 0; it < 8; it++) begin
         sw = rand_bits(8);
         rnd = rand_bits(8);
         clk_status = rand_bits(1) != 0;
         serdes_link_up = rand_bits(1) != 0;
         bus_write(set_addr(SR_LED), sw);
         bus_write(set_addr(SR_LED_SRC), rnd);
         wait_cycles(2);
         post_check("leds", predict(REF_LEDS, sw, rnd, {30'b0, clk_status, serdes_link_up}),
                    {24'b0, leds});
      end
      end_test("led_source");

      // Mask first, pending cleared from a quiet start
      irq = '0;
      wait_cycles(3);
      mask = rand_bits(NUM_IRQ);
      bus_write(PIC_BASE, mask);
      bus_write(PIC_PEND, '1);
      pend = '0;
      for (it = 0; it < 6; it++) begin
         lines = rand_bits(NUM_IRQ);
         irq = lines[NUM_IRQ-1:0];
         wait_cycles(3);
         irq = '0;
         wait_cycles(3);
         pend = predict(REF_EDGE, pend, '0, lines);
         bus_read(PIC_PEND, rdat);
         post_check("pic_pending", pend, rdat);
         post_check("int_o", predict(REF_INT, pend, mask, '0), {31'b0, int_out});
         if (it % 2 == 1) begin
            rnd = rand_bits(NUM_IRQ);
            bus_write(PIC_PEND, rnd);
            pend = predict(REF_CLR, pend, rnd, '0);
            bus_read(PIC_PEND, rdat);
            post_check("pic_cleared", pend, rdat);
            post_check("int_o_cleared", predict(REF_INT, pend, mask, '0), {31'b0, int_out});
         end
      end
      bus_read(PIC_BASE, rdat);
      post_check("pic_mask", mask, rdat);
      end_test("interrupts");

      for (it = 0; it < 4; it++) begin
         irq = '0;
         rnd = rand_bits(5);
         sim_mode = rnd[4];
         clock_divider = rnd[3:0];
         wait_cycles(3);
         bus_write(PIC_PEND, '1);
         lines = rand_bits(NUM_IRQ);
         irq = lines[NUM_IRQ-1:0];
         wait_cycles(3);
         bus_read(rdbk_addr(4'd9), rdat);
         post_check("word9", predict(REF_WORD9, {31'b0, sim_mode}, {28'b0, clock_divider}, '0),
                    rdat);
         bus_read(rdbk_addr(4'd13), rdat);
         post_check("word13_irq", lines, rdat);
         bus_read(rdbk_addr(4'd14), rdat);
         post_check("word14_prio", predict(REF_PRIO, lines, '0, '0), rdat);
         bus_read(rdbk_addr(4'd12), rdat);
         post_check("word12_pend", predict(REF_EDGE, '0, '0, lines), rdat);
         bus_read(rdbk_addr(4'd3), rdat);
         post_check("word3_zero", '0, rdat);
      end
      irq = '0;

      // Counter spacing follows the spacing of the acks
      for (it = 0; it < 3; it++) begin
         bus_read(rdbk_addr(4'd15), c1);
         t1 = last_ack_cycle;
         wait_cycles(int'(rand_bits(4)) + 1);
         bus_read(rdbk_addr(4'd15), rdat);
         post_check("counter_delta", 32'(last_ack_cycle - t1), rdat - c1);
      end
      end_test("readback");

      bus_read(UNMAPPED, rdat);
      post_check("unmapped_err", 32'd1, {31'b0, last_err});
      post_check("unmapped_ack", 32'd0, {31'b0, last_ack});
      bus_read(set_addr(SR_LED), rdat);
      post_check("settings_read", '0, rdat);
      post_check("settings_ack", 32'd1, {31'b0, last_ack});
      end_test("decoding");

      $display("Summary: %0d tests, %0d checks, %0d errors",
               test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_u2_ctrl_props.sv
/* Concurrent checks on the Wishbone handshake and the one-cycle setting strobe */

`timescale 1ns/1ps
`default_nettype none

module tb_u2_ctrl_props (
   input wire                        clk_i,
   input wire                        rst_i,
   input wire u2_ctrl_pkg::wb_req_t  req_i,
   input wire u2_ctrl_pkg::wb_rsp_t  rsp_i,
   input wire                        set_stb_i
);

   ////////////////////
   // Setting strobe

   // One pulse per accepted write
   a_set_stb_single: assert property (
      @(posedge clk_i) disable iff (rst_i)
      set_stb_i |=> !set_stb_i
   ) else $error("setting strobe held high for two cycles");

   ////////////////////
   // Handshake

   // A reply is either ack or err, never both
   a_ack_err_excl: assert property (
      @(posedge clk_i) disable iff (rst_i)
      !(rsp_i.ack && rsp_i.err)
   ) else $error("ack and err high together");

   // Ack answers a strobe seen one edge earlier
   a_ack_after_stb: assert property (
      @(posedge clk_i) disable iff (rst_i)
      rsp_i.ack |-> $past(req_i.cyc && req_i.stb)
   ) else $error("ack without a strobe in the previous cycle");

endmodule

`default_nettype wire

// File: u2_ctrl_top.sv
/* Control-plane top level
   Decoder, settings bus, setting registers, interrupt controller and readback window */

`timescale 1ns/1ps
`default_nettype none

module u2_ctrl_top #(
   parameter int NUM_IRQ = u2_ctrl_pkg::NUM_IRQ
) (
   input  wire                  dsp_clk,
   input  wire                  wb_rst,
   // Bus master
   input  wire u2_ctrl_pkg::wb_req_t  wb_req_i,
   output u2_ctrl_pkg::wb_rsp_t       wb_rsp_o,
   // Interrupt and status inputs
   input  wire [NUM_IRQ-1:0]    irq_i,
   input  wire                  clk_status_i,
   input  wire                  serdes_link_up_i,
   input  wire                  sim_mode_i,
   input  wire [3:0]            clock_divider_i,
   // Pins
   output u2_ctrl_pkg::clock_ctrl_t   clock_ctrl_o,
   output u2_ctrl_pkg::serdes_ctrl_t  serdes_ctrl_o,
   output u2_ctrl_pkg::adc_ctrl_t     adc_ctrl_o,
   output logic                 phy_resetn_o,
   output logic [7:0]           leds_o,
   output logic                 int_o
);

   import u2_ctrl_pkg::*;

   wb_req_t            rdbk_req;
   wb_req_t            set_req;
   wb_req_t            pic_req;
   wb_rsp_t            rdbk_rsp;
   wb_rsp_t            set_rsp;
   wb_rsp_t            pic_rsp;
   set_bus_t           set_bus;
   logic [NUM_IRQ-1:0] pending;

   ////////////////////
   // Bus fabric
   wb_decoder u_decoder (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .m_req_i   (wb_req_i),
      .m_rsp_o   (wb_rsp_o),
      .rdbk_req_o(rdbk_req),
      .set_req_o (set_req),
      .pic_req_o (pic_req),
      .rdbk_rsp_i(rdbk_rsp),
      .set_rsp_i (set_rsp),
      .pic_rsp_i (pic_rsp)
   );

   ////////////////////
   // Settings path
   settings_bus u_settings (
      .dsp_clk(dsp_clk),
      .wb_rst (wb_rst),
      .req_i  (set_req),
      .rsp_o  (set_rsp),
      .set_o  (set_bus)
   );

   control_regs u_regs (
      .dsp_clk         (dsp_clk),
      .wb_rst          (wb_rst),
      .set_i           (set_bus),
      .clk_status_i    (clk_status_i),
      .serdes_link_up_i(serdes_link_up_i),
      .clock_ctrl_o    (clock_ctrl_o),
      .serdes_ctrl_o   (serdes_ctrl_o),
      .adc_ctrl_o      (adc_ctrl_o),
      .phy_resetn_o    (phy_resetn_o),
      .leds_o          (leds_o)
   );

   ////////////////////
   // Interrupts and status

   // Raw lines feed both the controller and the readback window
   pic #(.NUM_IRQ(NUM_IRQ)) u_pic (
      .dsp_clk  (dsp_clk),
      .wb_rst   (wb_rst),
      .req_i    (pic_req),
      .rsp_o    (pic_rsp),
      .irq_i    (irq_i),
      .pending_o(pending),
      .int_o    (int_o)
   );

   readback_mux #(.NUM_IRQ(NUM_IRQ)) u_rdbk (
      .dsp_clk        (dsp_clk),
      .wb_rst         (wb_rst),
      .req_i          (rdbk_req),
      .rsp_o          (rdbk_rsp),
      .irq_i          (irq_i),
      .pending_i      (pending),
      .sim_mode_i     (sim_mode_i),
      .clock_divider_i(clock_divider_i)
   );

endmodule

`default_nettype wire

// File: readback_mux.sv
/* Sixteen-word status readback window
   Free-running cycle counter and priority encoder over the raw interrupt lines */

`timescale 1ns/1ps
`default_nettype none

module readback_mux #(
   parameter int NUM_IRQ = u2_ctrl_pkg::NUM_IRQ
) (
   input  wire                  dsp_clk,
   input  wire                  wb_rst,
   input  wire u2_ctrl_pkg::wb_req_t  req_i,
   output u2_ctrl_pkg::wb_rsp_t       rsp_o,
   input  wire [NUM_IRQ-1:0]    irq_i,
   input  wire [NUM_IRQ-1:0]    pending_i,
   input  wire                  sim_mode_i,
   input  wire [3:0]            clock_divider_i
);

   import u2_ctrl_pkg::*;

   logic             req_new;
   logic             ack_q;
   logic [WB_DW-1:0] dat_q;
   logic [WB_DW-1:0] word;
   logic [WB_DW-1:0] prio;
   logic [31:0]      cycle_cnt;

   assign req_new = req_i.cyc & req_i.stb & ~ack_q;

   // Counts every clock out of reset
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_cnt <= '0;
         ack_q     <= 1'b0;
      end else begin
         cycle_cnt <= cycle_cnt + 32'd1;
         ack_q     <= req_new;
      end
   end

   // Highest set line plus one, zero when idle
   always_comb begin
      prio = '0;
      for (int i = 0; i < NUM_IRQ; i++) begin
         if (irq_i[i]) begin
            prio = WB_DW'(i + 1);
         end
      end
   end

   ////////////////////
   // Word select

   always_comb begin
      case (req_i.adr[5:2])
         4'd9:    word = {sim_mode_i, 27'b0, clock_divider_i};
         4'd12:   word = WB_DW'(pending_i);
         4'd13:   word = WB_DW'(irq_i);
         4'd14:   word = prio;
         4'd15:   word = cycle_cnt;
         default: word = '0;  // Buffer status words, not present
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (req_new) begin
         dat_q <= word;
      end
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q, err: 1'b0};

endmodule

`default_nettype wire

// File: pic.sv
/* Interrupt controller with edge-latched pending bits
   Word 0 mask, word 1 pending with write-one-to-clear */

`timescale 1ns/1ps
`default_nettype none

module pic #(
   parameter int NUM_IRQ = u2_ctrl_pkg::NUM_IRQ
) (
   input  wire                  dsp_clk,
   input  wire                  wb_rst,
   input  wire u2_ctrl_pkg::wb_req_t  req_i,
   output u2_ctrl_pkg::wb_rsp_t       rsp_o,
   input  wire [NUM_IRQ-1:0]    irq_i,
   output logic [NUM_IRQ-1:0]   pending_o,
   output logic                 int_o
);

   import u2_ctrl_pkg::*;

   logic                req_new;
   logic                wr_mask;
   logic                wr_clr;
   logic                ack_q;
   logic [WB_DW-1:0]    dat_q;
   logic [NUM_IRQ-1:0]  irq_q;
   logic [NUM_IRQ-1:0]  irq_d;
   logic [NUM_IRQ-1:0]  rise;
   logic [NUM_IRQ-1:0]  clr;
   logic [NUM_IRQ-1:0]  mask_q;
   logic [NUM_IRQ-1:0]  pend_q;

   // Bus decode, address bit 2 selects the word
   assign req_new = req_i.cyc & req_i.stb & ~ack_q;
   assign wr_mask = req_new & req_i.we & ~req_i.adr[2];
   assign wr_clr  = req_new & req_i.we & req_i.adr[2];
   assign clr     = wr_clr ? req_i.dat[NUM_IRQ-1:0] : '0;

   // Low in the previous sample, high in this one
   assign rise = irq_q & ~irq_d;

   ////////////////////
   // Interrupt state

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         irq_q  <= '0;
         irq_d  <= '0;
         mask_q <= '0;
         pend_q <= '0;
         ack_q  <= 1'b0;
      end else begin
         irq_q <= irq_i;
         irq_d <= irq_q;
         ack_q <= req_new;
         if (wr_mask) begin
            mask_q <= req_i.dat[NUM_IRQ-1:0];
         end
         // A new edge beats a clear in the same cycle
         pend_q <= (pend_q & ~clr) | rise;
      end
   end

   // Read data captured with the access
   always_ff @(posedge dsp_clk) begin
      if (req_new) begin
         dat_q <= req_i.adr[2] ? WB_DW'(pend_q) : WB_DW'(mask_q);
      end
   end

   assign rsp_o     = '{dat: dat_q, ack: ack_q, err: 1'b0};
   assign pending_o = pend_q;
   assign int_o     = |(pend_q & mask_q);

endmodule

`default_nettype wire

// File: control_regs.sv
/* Setting register bank for clock, SERDES, ADC and PHY pins
   Software LED register and per-bit LED source selection */

`timescale 1ns/1ps
`default_nettype none

module control_regs (
   input  wire                  dsp_clk,
   input  wire                  wb_rst,
   input  wire u2_ctrl_pkg::set_bus_t set_i,
   // Status seen on the hardware LEDs
   input  wire                  clk_status_i,
   input  wire                  serdes_link_up_i,
   // Pin groups
   output u2_ctrl_pkg::clock_ctrl_t   clock_ctrl_o,
   output u2_ctrl_pkg::serdes_ctrl_t  serdes_ctrl_o,
   output u2_ctrl_pkg::adc_ctrl_t     adc_ctrl_o,
   output logic                 phy_resetn_o,
   output logic [7:0]           leds_o
);

   import u2_ctrl_pkg::*;

   clock_ctrl_t  clk_q;
   serdes_ctrl_t ser_q;
   adc_ctrl_t    adc_q;
   logic         phy_q;
   logic [7:0]   led_sw_q;
   logic [7:0]   led_src_q;
   logic [7:0]   led_hw;

   ////////////////////
   // Register bank

   // Low data bits load the field, unknown addresses are ignored
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clk_q     <= '0;
         ser_q     <= '0;
         adc_q     <= '0;
         phy_q     <= 1'b0;
         led_sw_q  <= '0;
         led_src_q <= '0;
      end else if (set_i.stb) begin
         case (set_i.addr)
            SR_CLK:     clk_q     <= set_i.data[$bits(clock_ctrl_t)-1:0];
            SR_SER:     ser_q     <= set_i.data[$bits(serdes_ctrl_t)-1:0];
            SR_ADC:     adc_q     <= set_i.data[$bits(adc_ctrl_t)-1:0];
            SR_LED:     led_sw_q  <= set_i.data[7:0];
            SR_PHY:     phy_q     <= set_i.data[0];
            SR_LED_SRC: led_src_q <= set_i.data[7:0];
            default: ;
         endcase
      end
   end

   ////////////////////
   // Pin outputs

   assign clock_ctrl_o  = clk_q;
   assign serdes_ctrl_o = ser_q;
   assign adc_ctrl_o    = adc_q;

   // Bit 0 of the PHY word holds the part in reset
   assign phy_resetn_o = ~phy_q;

   // Hardware status word, upper LEDs have no hardware source
   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};

   // Source bit set picks hardware, clear picks software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

`default_nettype wire

// File: settings_bus.sv
/* Wishbone slave for the settings window
   Each write becomes a one-cycle strobe with word address and data */

`timescale 1ns/1ps
`default_nettype none

module settings_bus (
   input  wire                  dsp_clk,
   input  wire                  wb_rst,
   input  wire u2_ctrl_pkg::wb_req_t  req_i,
   output u2_ctrl_pkg::wb_rsp_t       rsp_o,
   output u2_ctrl_pkg::set_bus_t      set_o
);

   import u2_ctrl_pkg::*;

   logic             req_new;
   logic             ack_q;
   logic             stb_q;
   logic [7:0]       addr_q;
   logic [WB_DW-1:0] data_q;

   // First cycle of a strobe, the ack of the previous cycle blocks a repeat
   assign req_new = req_i.cyc & req_i.stb & ~ack_q;

   // Control flags
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
         stb_q <= 1'b0;
      end else begin
         ack_q <= req_new;
         stb_q <= req_new & req_i.we;
      end
   end

   // Word address and payload, captured with the strobe
   always_ff @(posedge dsp_clk) begin
      if (req_new & req_i.we) begin
         addr_q <= req_i.adr[9:2];
         data_q <= req_i.dat;
      end
   end

   assign set_o = '{stb: stb_q, addr: addr_q, data: data_q};

   // Write-only window, reads give zero
   assign rsp_o = '{dat: '0, ack: ack_q, err: 1'b0};

endmodule

`default_nettype wire

// File: wb_decoder.sv
/* Single-master Wishbone address decoder
   Strobe gating per slave, response multiplexer, error reply for unmapped space */

`timescale 1ns/1ps
`default_nettype none

module wb_decoder (
   input  wire                  dsp_clk,
   input  wire                  wb_rst,
   // Master port
   input  wire u2_ctrl_pkg::wb_req_t  m_req_i,
   output u2_ctrl_pkg::wb_rsp_t       m_rsp_o,
   // Slave ports
   output u2_ctrl_pkg::wb_req_t       rdbk_req_o,
   output u2_ctrl_pkg::wb_req_t       set_req_o,
   output u2_ctrl_pkg::wb_req_t       pic_req_o,
   input  wire u2_ctrl_pkg::wb_rsp_t  rdbk_rsp_i,
   input  wire u2_ctrl_pkg::wb_rsp_t  set_rsp_i,
   input  wire u2_ctrl_pkg::wb_rsp_t  pic_rsp_i
);

   import u2_ctrl_pkg::*;

   logic [DECODE_W-1:0] dec;
   logic                hit_rdbk;
   logic                hit_set;
   logic                hit_pic;
   logic                miss;
   logic                err_q;

   // Same request to every slave, strobe only where the address lands
   function automatic wb_req_t gate_req(input wb_req_t req, input logic hit);
      wb_req_t g;
      g     = req;
      g.cyc = req.cyc & hit;
      g.stb = req.stb & hit;
      return g;
   endfunction

   // Upper address bits select the slave
   assign dec      = m_req_i.adr[WB_AW-1 -: DECODE_W];
   assign hit_rdbk = (dec == SLV_RDBK);
   assign hit_set  = (dec == SLV_SETTINGS);
   assign hit_pic  = (dec == SLV_PIC);
   assign miss     = ~(hit_rdbk | hit_set | hit_pic);

   assign rdbk_req_o = gate_req(m_req_i, hit_rdbk);
   assign set_req_o  = gate_req(m_req_i, hit_set);
   assign pic_req_o  = gate_req(m_req_i, hit_pic);

   ////////////////////
   // Unmapped space

   // One-cycle err pulse, the master drops stb after it
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= miss & m_req_i.cyc & m_req_i.stb & ~err_q;
      end
   end

   ////////////////////
   // Response path

   // Address is held until the reply, so it also picks the response
   always_comb begin
      case (dec)
         SLV_RDBK:     m_rsp_o = rdbk_rsp_i;
         SLV_SETTINGS: m_rsp_o = set_rsp_i;
         SLV_PIC:      m_rsp_o = pic_rsp_i;
         default:      m_rsp_o = '{dat: '0, ack: 1'b0, err: err_q};
      endcase
   end

endmodule

`default_nettype wire

// File: u2_ctrl_pkg.sv
/* Bus widths, address map and setting addresses for the control core
   Packed structs for the Wishbone request and response, the settings bus and the pin groups */

`default_nettype none

package u2_ctrl_pkg;

   // Wishbone geometry
   localparam int WB_DW    = 32;  // Data width
   localparam int WB_AW    = 16;  // Byte address width
   localparam int WB_SW    = 4;   // One select bit per byte lane
   localparam int DECODE_W = 6;   // Upper address bits seen by the decoder

   ////////////////////
   // Slave decode values
   localparam logic [DECODE_W-1:0] SLV_RDBK     = 6'b1100_11;  // Status readback window
   localparam logic [DECODE_W-1:0] SLV_SETTINGS = 6'b1101_01;  // Settings bus writes
   localparam logic [DECODE_W-1:0] SLV_PIC      = 6'b1101_10;  // Interrupt controller

   ////////////////////
   // Setting register addresses
   localparam logic [7:0] SR_CLK     = 8'd0;
   localparam logic [7:0] SR_SER     = 8'd1;
   localparam logic [7:0] SR_ADC     = 8'd2;
   localparam logic [7:0] SR_LED     = 8'd3;
   localparam logic [7:0] SR_PHY     = 8'd4;
   localparam logic [7:0] SR_LED_SRC = 8'd8;

   // Interrupt line count
   localparam int NUM_IRQ = 8;

   ////////////////////
   // Bus and pin structs

   // Master side of a Wishbone cycle
   typedef struct packed {
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
      logic [WB_SW-1:0] sel;
      logic             we;
      logic             cyc;
      logic             stb;
   } wb_req_t;

   // Slave answer
   typedef struct packed {
      logic [WB_DW-1:0] dat;
      logic             ack;
      logic             err;
   } wb_rsp_t;

   // One-cycle setting write
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Field order matches the low data bits of each setting word
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

endpackage

`default_nettype wire
